//--- Bender.yml
package:
  name: approx_mac

sources:
  - include_dirs:
      - source
    files:
      - source/mac_op_pkg.sv
      - source/mac_data_pkg.sv
      - source/approx_mul_33.sv
      - source/mac_ctrl.sv
      - source/err_monitor.sv
      - source/mac_accum.sv
      - source/approx_mac_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clk_gen.sv
      - tb/approx_mac_tb.sv

//--- list.f
+incdir+source
source/mac_op_pkg.sv
source/mac_data_pkg.sv
source/approx_mul_33.sv
source/mac_ctrl.sv
source/err_monitor.sv
source/mac_accum.sv
source/approx_mac_top.sv
tb/tb_clk_gen.sv
tb/approx_mac_tb.sv

//--- source/approx_mac_top.sv
`default_nettype none

`include "mac_defs.svh"

module approx_mac_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire mac_op_pkg::mac_cmd_t   cmd,
    input  wire                         cmd_valid,
    output logic                        cmd_ready,
    output mac_data_pkg::mac_result_t   result,
    output logic                        result_valid,
    input  wire                         result_ready
);

    mac_op_pkg::mac_tag_t         s1_tag;
    mac_op_pkg::mac_tag_t         s2_tag;
    mac_data_pkg::prod_pair_t     pair;
    logic [`MAC_PROD_W-1:0]       approx;
    logic signed [`MAC_ACC_W-1:0] acc;
    logic [`MAC_ERR_W-1:0]        err_sum;
    logic [`MAC_PROD_W-1:0]       err_max;
    logic [`MAC_PROD_W-1:0]       approx_cnt;

    mac_ctrl mac_ctrl_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_op       (cmd.op),
        .s1_tag       (s1_tag),
        .s2_tag       (s2_tag),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    approx_mul_33 approx_mul_33_i (
        .x (cmd.a),
        .y (cmd.b),
        .z (approx)
    );

    err_monitor err_monitor_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .a          (cmd.a),
        .b          (cmd.b),
        .approx     (approx),
        .s1_tag     (s1_tag),
        .s2_tag     (s2_tag),
        .pair       (pair),
        .err_sum    (err_sum),
        .err_max    (err_max),
        .approx_cnt (approx_cnt)
    );

    mac_accum mac_accum_i (
        .clk    (clk),
        .arst_n (arst_n),
        .s2_tag (s2_tag),
        .pair   (pair),
        .acc    (acc)
    );

    // stable while result_valid, no command reaches the stages then
    assign result.acc        = acc;
    assign result.err_sum    = err_sum;
    assign result.err_max    = err_max;
    assign result.approx_cnt = approx_cnt;

endmodule

`default_nettype wire

//--- source/approx_mul_33.sv
`default_nettype none

`include "mac_defs.svh"

module approx_mul_33 (
    input  wire signed [`MAC_OPND_W-1:0] x,
    input  wire signed [`MAC_OPND_W-1:0] y,
    output logic [`MAC_PROD_W-1:0]       z
);

    logic [`MAC_OPND_W-1:0][`MAC_OPND_W-1:0] pp; // baugh-wooley rows
    logic [20:0] c0;
    logic [20:0] c1;
    logic [20:0] c2;
    logic [20:0] c3;

    always_comb begin
        for (int i = 0; i < 15; i++) begin
            pp[i] = {~(y[15] & x[i]), y[14:0] & {15{x[i]}}}; // sign term inverted
        end
        pp[15] = {y[15] & x[15], ~(y[14:0] & {15{x[15]}})};
    end

    // rows 0 to 5 folded into four sparse rows, columns 0 to 3 dropped
    always_comb begin
        c0 = '0;
        c1 = '0;
        c2 = '0;
        c3 = '0;

        c0[4]  = pp[0][4] ^ pp[1][3];
        c0[5]  = pp[0][4] & pp[1][3];
        c0[7]  = pp[0][7] ^ pp[1][6];
        c0[8]  = pp[0][7] | pp[1][6];  // or in place of carry
        c0[9]  = pp[0][8] & pp[1][7];
        c0[11] = pp[0][11] ^ pp[1][10];
        c0[12] = pp[0][11] & pp[1][10];
        c0[13] = pp[0][12] & pp[1][11];
        c0[16] = ~pp[1][15];           // half adder with row 0 correction one
        c0[17] = pp[1][15];
        c0[18] = pp[2][15] & pp[3][14];
        c0[19] = pp[4][14] & pp[5][13];
        c0[20] = pp[4][15] & pp[5][14];

        c1[7]  = pp[4][3] ^ pp[5][2];
        c1[8]  = pp[4][4] ^ pp[5][3];
        c1[9]  = pp[0][9] ^ pp[1][8];
        c1[11] = pp[2][8] & pp[3][7];
        c1[13] = pp[2][11] ^ pp[3][10];
        c1[16] = pp[4][12] ^ pp[5][11];
        c1[17] = pp[2][14] & pp[3][13];
        c1[18] = pp[3][15];
        c1[19] = pp[4][15] ^ pp[5][14];
        c1[20] = pp[5][15];

        c2[9]  = pp[4][5] ^ pp[5][4];
        c2[13] = pp[4][9] ^ pp[5][8];
        c2[17] = pp[2][15] ^ pp[3][14];
        c2[18] = pp[4][13] | pp[5][12];

        c3[18] = pp[4][14] ^ pp[5][13];
    end

    always_comb begin
        z = {1'b1, pp[15], 15'b0}; // top row plus correction one at bit 31
        for (int i = 6; i < 15; i++) begin
            z = z + ({16'b0, pp[i]} << i);
        end
        z = z + {11'b0, c0} + {11'b0, c1} + {11'b0, c2} + {11'b0, c3};
    end

endmodule

`default_nettype wire

//--- source/err_monitor.sv
`default_nettype none

`include "mac_defs.svh"

module err_monitor (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire signed [`MAC_OPND_W-1:0] a,
    input  wire signed [`MAC_OPND_W-1:0] b,
    input  wire [`MAC_PROD_W-1:0]        approx,
    input  wire mac_op_pkg::mac_tag_t    s1_tag,
    input  wire mac_op_pkg::mac_tag_t    s2_tag,
    output mac_data_pkg::prod_pair_t     pair,
    output logic [`MAC_ERR_W-1:0]        err_sum,
    output logic [`MAC_PROD_W-1:0]       err_max,
    output logic [`MAC_PROD_W-1:0]       approx_cnt
);

    logic signed [`MAC_PROD_W-1:0] exact;
    logic [`MAC_PROD_W:0]          diff; // one extra bit for sign
    logic [`MAC_PROD_W-1:0]        abs_err;

    assign exact   = a * b;
    assign diff    = {pair.approx[`MAC_PROD_W-1], pair.approx}
                   - {pair.exact[`MAC_PROD_W-1], pair.exact};
    assign abs_err = diff[`MAC_PROD_W] ? (~diff[`MAC_PROD_W-1:0] + 1'b1)
                                       : diff[`MAC_PROD_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair <= '0;
        end else if (s1_tag.valid) begin
            pair.approx <= approx;
            pair.exact  <= exact;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            err_sum    <= '0;
            err_max    <= '0;
            approx_cnt <= '0;
        end else if (s2_tag.valid) begin
            case (s2_tag.op)
                mac_op_pkg::OP_CLEAR: begin
                    err_sum    <= '0;
                    err_max    <= '0;
                    approx_cnt <= '0;
                end
                mac_op_pkg::OP_MAC_APPROX: begin
                    err_sum    <= err_sum + {{(`MAC_ERR_W-`MAC_PROD_W){1'b0}}, abs_err};
                    approx_cnt <= approx_cnt + 1'b1;
                    if (abs_err > err_max) err_max <= abs_err;
                end
                default: ;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !(s2_tag.valid && s2_tag.op == mac_op_pkg::OP_CLEAR) |=> err_sum >= $past(err_sum));

endmodule

`default_nettype wire

//--- source/mac_accum.sv
`default_nettype none

`include "mac_defs.svh"

module mac_accum (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire mac_op_pkg::mac_tag_t     s2_tag,
    input  wire mac_data_pkg::prod_pair_t pair,
    output logic signed [`MAC_ACC_W-1:0]  acc
);

    logic signed [`MAC_PROD_W-1:0] prod;
    logic signed [`MAC_ACC_W-1:0]  prod_ext;

    assign prod     = (s2_tag.op == mac_op_pkg::OP_MAC_EXACT) ? pair.exact : pair.approx;
    assign prod_ext = {{(`MAC_ACC_W-`MAC_PROD_W){prod[`MAC_PROD_W-1]}}, prod};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (s2_tag.valid) begin
            case (s2_tag.op)
                mac_op_pkg::OP_CLEAR:      acc <= '0;
                mac_op_pkg::OP_MAC_APPROX,
                mac_op_pkg::OP_MAC_EXACT:  acc <= acc + prod_ext; // wraps, no saturation
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mac_ctrl.sv
`default_nettype none

module mac_ctrl (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  cmd_valid,
    output logic                 cmd_ready,
    input  wire mac_op_pkg::mac_op_e cmd_op,
    output mac_op_pkg::mac_tag_t s1_tag,
    output mac_op_pkg::mac_tag_t s2_tag,
    output logic                 result_valid,
    input  wire                  result_ready
);

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        RESP
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   accept;

    assign cmd_ready    = (state == IDLE);
    assign accept       = cmd_valid && cmd_ready;
    assign result_valid = (state == RESP);

    // reads never enter the datapath stages
    assign s1_tag.valid = accept && (cmd_op != mac_op_pkg::OP_READ);
    assign s1_tag.op    = cmd_op;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (accept && cmd_op == mac_op_pkg::OP_READ) state_nxt = DRAIN;
            DRAIN:   if (!s1_tag.valid && !s2_tag.valid) state_nxt = RESP;
            RESP:    if (result_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            s2_tag <= '0;
        end else begin
            state  <= state_nxt;
            s2_tag <= s1_tag;
        end
    end

    // result only shows once the pipeline is empty
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(result_valid) |-> !s1_tag.valid && !s2_tag.valid);

    // no command slips in between a read and its result transfer
    assert property (@(posedge clk) disable iff (!arst_n)
        accept && cmd_op == mac_op_pkg::OP_READ |=>
            !cmd_ready until_with (result_valid && result_ready));

endmodule

`default_nettype wire

//--- source/mac_data_pkg.sv
`default_nettype none

`include "mac_defs.svh"

package mac_data_pkg;

    typedef struct packed {
        logic signed [`MAC_PROD_W-1:0] approx; // from approx_mul_33
        logic signed [`MAC_PROD_W-1:0] exact;
    } prod_pair_t;

    typedef struct packed {
        logic signed [`MAC_ACC_W-1:0] acc;
        logic [`MAC_ERR_W-1:0]        err_sum;
        logic [`MAC_PROD_W-1:0]       err_max;
        logic [`MAC_PROD_W-1:0]       approx_cnt; // approx macs since clear
    } mac_result_t;

endpackage

`default_nettype wire

//--- source/mac_defs.svh
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// signed operand width, fixed by the approximate multiplier
`define MAC_OPND_W 16

// full product width
`define MAC_PROD_W 32

// accumulator width, wraps modulo 2^40
`define MAC_ACC_W 40

// error sum width, room for 2^16 worst-case errors
`define MAC_ERR_W 48

`endif

//--- source/mac_op_pkg.sv
`default_nettype none

`include "mac_defs.svh"

package mac_op_pkg;

    typedef enum logic [1:0] {
        OP_CLEAR      = 2'b00, // zero accumulator and statistics
        OP_MAC_APPROX = 2'b01,
        OP_MAC_EXACT  = 2'b10,
        OP_READ       = 2'b11  // return result
    } mac_op_e;

    typedef struct packed {
        mac_op_e                       op;
        logic signed [`MAC_OPND_W-1:0] a;
        logic signed [`MAC_OPND_W-1:0] b;
    } mac_cmd_t;

    typedef struct packed {
        logic    valid;
        mac_op_e op;
    } mac_tag_t;

endpackage

`default_nettype wire

//--- tb/approx_mac_tb.sv
`default_nettype none

`include "mac_defs.svh"

module approx_mac_tb;

    localparam int NUM_WRAP   = 1100;
    localparam int NUM_RAND   = 400;
    localparam int NUM_CMDS   = NUM_WRAP + NUM_RAND + 12;
    localparam int WATCHDOG_T = (8 + NUM_CMDS * 20) * 10;

    logic                      clk;
    logic                      arst_n;
    mac_op_pkg::mac_cmd_t      cmd;
    logic                      cmd_valid;
    logic                      cmd_ready;
    mac_data_pkg::mac_result_t result;
    logic                      result_valid;
    logic                      result_ready;
    mac_data_pkg::mac_result_t model; // expected accumulator and statistics
    integer                    seed = 92;

    tb_clk_gen tb_clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    approx_mac_top approx_mac_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_acc(input string name, input logic signed [`MAC_ACC_W-1:0] got,
                             input logic signed [`MAC_ACC_W-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_err(input string name, input logic [`MAC_ERR_W-1:0] got,
                             input logic [`MAC_ERR_W-1:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_result(input string name, input mac_data_pkg::mac_result_t got,
                                input mac_data_pkg::mac_result_t exp);
        check_acc({name, ".acc"}, got.acc, exp.acc);
        check_err({name, ".err_sum"}, got.err_sum, exp.err_sum);
        check_err({name, ".err_max"}, got.err_max, exp.err_max);
        check_err({name, ".approx_cnt"}, got.approx_cnt, exp.approx_cnt);
    endtask

    function automatic logic [63:0] col_term(input int col, input logic v);
        return 64'(v) << col;
    endfunction

    // baugh-wooley rows with columns 0 to 3 dropped and rows 0 to 5 compressed
    function automatic logic [`MAC_PROD_W-1:0] approx_prod(input logic [15:0] x,
                                                          input logic [15:0] y);
        logic [15:0] p [16];
        logic [63:0] s;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                p[i][j] = (y[j] & x[i]) ^ ((i == 15) != (j == 15)); // sign terms inverted
            end
        end
        s = 64'd1 << 31; // correction one of the top column
        for (int i = 6; i < 16; i++) begin
            for (int j = 0; j < 16; j++) begin
                s += col_term(i + j, p[i][j]);
            end
        end
        // rows 0 and 1 with the column 16 correction one
        s += col_term(4, p[0][4] ^ p[1][3]) + col_term(5, p[0][4] & p[1][3]);
        s += col_term(7, p[0][7] ^ p[1][6]) + col_term(8, p[0][7] | p[1][6]);
        s += col_term(9, p[0][8] & p[1][7]) + col_term(9, p[0][9] ^ p[1][8]);
        s += col_term(11, p[0][11] ^ p[1][10]) + col_term(12, p[0][11] & p[1][10]);
        s += col_term(13, p[0][12] & p[1][11]);
        s += col_term(16, ~p[1][15]) + col_term(17, p[1][15]);
        // rows 2 and 3
        s += col_term(11, p[2][8] & p[3][7]) + col_term(13, p[2][11] ^ p[3][10]);
        s += col_term(17, p[2][14] & p[3][13]) + col_term(17, p[2][15] ^ p[3][14]);
        s += col_term(18, p[2][15] & p[3][14]) + col_term(18, p[3][15]);
        // rows 4 and 5
        s += col_term(7, p[4][3] ^ p[5][2]) + col_term(8, p[4][4] ^ p[5][3]);
        s += col_term(9, p[4][5] ^ p[5][4]) + col_term(13, p[4][9] ^ p[5][8]);
        s += col_term(16, p[4][12] ^ p[5][11]) + col_term(18, p[4][13] | p[5][12]);
        s += col_term(18, p[4][14] ^ p[5][13]) + col_term(19, p[4][14] & p[5][13]);
        s += col_term(19, p[4][15] ^ p[5][14]) + col_term(20, p[4][15] & p[5][14]);
        s += col_term(20, p[5][15]);
        return s[31:0];
    endfunction

    task automatic model_update(input mac_op_pkg::mac_cmd_t c);
        logic signed [`MAC_PROD_W-1:0] ex;
        logic signed [`MAC_PROD_W-1:0] ap;
        longint                        d;
        ex = $signed(c.a) * $signed(c.b);
        ap = approx_prod(c.a, c.b);
        d  = longint'(ap) - longint'(ex);
        if (d < 0) d = -d;
        case (c.op)
            mac_op_pkg::OP_CLEAR: model = '0;
            mac_op_pkg::OP_MAC_EXACT: model.acc = model.acc + {{8{ex[31]}}, ex};
            mac_op_pkg::OP_MAC_APPROX: begin
                model.acc        = model.acc + {{8{ap[31]}}, ap};
                model.err_sum    = model.err_sum + 48'(d[31:0]);
                model.approx_cnt = model.approx_cnt + 1;
                if (d[31:0] > model.err_max) model.err_max = d[31:0];
            end
            default: ;
        endcase
    endtask

    function automatic logic signed [15:0] rand_opnd();
        int pick;
        pick = $random(seed) & 7;
        case (pick)
            0:       return 16'sh8000;
            1:       return 16'sh7fff;
            2:       return 16'($random(seed)) & 16'hfff0; // low nibble zero
            default: return 16'($random(seed));
        endcase
    endfunction

    function automatic mac_op_pkg::mac_cmd_t make_cmd(input mac_op_pkg::mac_op_e op);
        mac_op_pkg::mac_cmd_t c;
        c.op = op;
        c.a  = rand_opnd();
        c.b  = rand_opnd();
        return c;
    endfunction

    // enters and leaves 1 unit after a rising edge
    task automatic send_cmd(input mac_op_pkg::mac_cmd_t c);
        int gap;
        gap = (($random(seed) & 3) == 0) ? ($random(seed) & 3) + 1 : 0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        cmd       = c;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        model_update(c);
    endtask

    task automatic do_read();
        int hold;
        send_cmd(make_cmd(mac_op_pkg::OP_READ));
        while (!result_valid) begin
            @(posedge clk);
            #1;
        end
        check_result("result", result, model);
        hold = $random(seed) & 7;
        repeat (hold) begin
            @(posedge clk);
            #1;
            if (!result_valid || cmd_ready)
                stop_with_failure("handshake changed while result_ready was low");
            check_result("held result", result, model);
        end
        result_ready = 1'b1;
        @(posedge clk);
        #1;
        result_ready = 1'b0;
        if (!cmd_ready || result_valid)
            stop_with_failure("cmd_ready did not return after the result transfer");
    endtask

    initial begin
        #(WATCHDOG_T);
        stop_with_failure("watchdog expired, the run hung waiting on a handshake");
    end

    initial begin
        mac_op_pkg::mac_cmd_t c;
        int                   r;
        cmd          = '0;
        cmd_valid    = 1'b0;
        result_ready = 1'b0;
        model        = '0;
        @(posedge arst_n);
        @(posedge clk);
        #1;
        if (!cmd_ready || result_valid) stop_with_failure("handshake outputs wrong after reset");

        // extreme exact products running past 2^40
        for (int k = 0; k < NUM_WRAP; k++) begin
            c.op = mac_op_pkg::OP_MAC_EXACT;
            c.a  = (k % 16 == 15) ? 16'sh7fff : 16'sh8000;
            c.b  = (k % 16 == 15) ? 16'sh7fff : 16'sh8000;
            send_cmd(c);
            if (k == 512) do_read();
        end
        do_read();

        send_cmd(make_cmd(mac_op_pkg::OP_MAC_APPROX));
        send_cmd(make_cmd(mac_op_pkg::OP_CLEAR));
        send_cmd(make_cmd(mac_op_pkg::OP_MAC_APPROX));
        send_cmd(make_cmd(mac_op_pkg::OP_MAC_EXACT));
        do_read();

        for (int k = 0; k < NUM_RAND; k++) begin
            r = $random(seed) & 15;
            if (r < 7) send_cmd(make_cmd(mac_op_pkg::OP_MAC_APPROX));
            else if (r < 12) send_cmd(make_cmd(mac_op_pkg::OP_MAC_EXACT));
            else if (r < 13) send_cmd(make_cmd(mac_op_pkg::OP_CLEAR));
            else do_read();
        end
        do_read();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // period 10
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire
